//--- sources.f
design/ring_pkg.sv
design/ring_mem.sv
design/ring_nic.sv
design/ring_top.sv
verification/ring_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module ring_tb -Mdir obj_dir -o ring_sim
	./obj_dir/ring_sim 2>&1 | tee sim.log
	! grep -q "Something failed" sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/ring_tb.sv
/* Message ring testbench: clock, reset, DUT, LFSR, memory model, check task
   and the directed tests */
module ring_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_NODES = 3;
	localparam int MEM_WORDS = 256;
	localparam int TIMEOUT   = 200;
	localparam int OPS       = 6;
	// Galois feedback taps for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] TAPS = 32'h8020_0003;

	logic clk = 1'b0;
	logic rst;
	ring_pkg::apb_req_t [NUM_NODES-1:0] cpu_req;
	ring_pkg::apb_rsp_t [NUM_NODES-1:0] cpu_rsp;

	logic [31:0] lfsr_state;
	// Expected contents of every node's memory
	logic [15:0] model [NUM_NODES][MEM_WORDS];
	// Stimulus for the concurrent test, drawn before the threads start
	int          op_did [NUM_NODES][OPS];
	int          op_adr [NUM_NODES][OPS];
	logic [15:0] op_dat [NUM_NODES][OPS];
	int pass_cnt;
	int fail_cnt;

	ring_top #(
		.NUM_NODES(NUM_NODES),
		.MEM_WORDS(MEM_WORDS)
	) uut (
		.clk_i    (clk),
		.rst_i    (rst),
		.cpu_req_i(cpu_req),
		.cpu_rsp_o(cpu_rsp)
	);

	always #10 clk = ~clk;

	// ========================================================================
	// Helpers
	// ========================================================================

	// Takes n bits from the LFSR, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (b) begin
				lfsr_state = lfsr_state ^ TAPS;
			end
			r = {r[30:0], b};
		end
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic test_done(input string name, input int fails_before);
		if (fail_cnt == fails_before) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: %0d errors", name, fail_cnt - fails_before);
		end
	endtask

	// One APB transfer on a node's CPU port
	// Strobes drop on the edge that ends the cycle with pready
	task automatic apb_xfer(input int node, input logic wr, input int did, input int adr,
		input logic [15:0] wdat, output logic [15:0] rdat, output logic slverr);
		int cycles = 0;
		@(posedge clk);
		cpu_req[node].psel    <= 1'b1;
		cpu_req[node].penable <= 1'b0;
		cpu_req[node].pwrite  <= wr;
		cpu_req[node].paddr   <= {4'(did), 12'(adr)};
		cpu_req[node].pwdata  <= wdat;
		@(posedge clk);
		cpu_req[node].penable <= 1'b1;
		// Outputs settle by the falling edge
		@(negedge clk);
		while (!cpu_rsp[node].pready) begin
			if (cycles >= TIMEOUT) begin
				$display("Node %0d CPU port gave no pready within %0d cycles", node, TIMEOUT);
				$display("Something failed");
				$finish;
			end else begin
				cycles++;
				@(negedge clk);
			end
		end
		rdat   = cpu_rsp[node].prdata;
		slverr = cpu_rsp[node].pslverr;
		@(posedge clk);
		cpu_req[node].psel    <= 1'b0;
		cpu_req[node].penable <= 1'b0;
	endtask

	task automatic write_word(input int node, input int did, input int adr,
		input logic [15:0] dat);
		logic [15:0] rdat;
		logic        err;
		apb_xfer(node, 1'b1, did, adr, dat, rdat, err);
		check($sformatf("node%0d pslverr", node), 32'(err), 32'h0);
		model[did][adr] = dat;
	endtask

	task automatic read_word(input int node, input int did, input int adr);
		logic [15:0] rdat;
		logic        err;
		apb_xfer(node, 1'b0, did, adr, 16'h0, rdat, err);
		check($sformatf("node%0d pslverr", node), 32'(err), 32'h0);
		check($sformatf("node%0d prdata", node), 32'(rdat), 32'(model[did][adr]));
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic test_reset();
		int f;
		f = fail_cnt;
		@(negedge clk);
		for (int n = 0; n < NUM_NODES; n++) begin
			check($sformatf("node%0d pready", n), 32'(cpu_rsp[n].pready), 32'h0);
			check($sformatf("node%0d pslverr", n), 32'(cpu_rsp[n].pslverr), 32'h0);
		end
		test_done("reset state", f);
	endtask

	task automatic test_remote();
		int f;
		int adr;
		f = fail_cnt;
		adr = int'(rand_bits(6));
		write_word(0, 2, adr, 16'(rand_bits(16)));
		read_word(1, 2, adr);
		test_done("remote write and read", f);
	endtask

	// The request leaves the node and comes back after a full lap
	task automatic test_own();
		int f;
		int adr;
		f = fail_cnt;
		for (int n = 0; n < NUM_NODES; n++) begin
			adr = int'(rand_bits(6));
			write_word(n, n, adr, 16'(rand_bits(16)));
			read_word(n, n, adr);
		end
		test_done("own memory", f);
	endtask

	task automatic test_bad_node();
		int          f;
		int          a0;
		int          a1;
		logic [15:0] rdat;
		logic        err;
		f = fail_cnt;
		a0 = int'(rand_bits(6));
		a1 = int'(rand_bits(6));
		write_word(2, 0, a0, 16'(rand_bits(16)));
		write_word(2, 1, a1, 16'(rand_bits(16)));
		apb_xfer(2, 1'b1, 5, a0, ~model[0][a0], rdat, err);
		check("node2 pslverr", 32'(err), 32'h1);
		apb_xfer(2, 1'b0, 5, a1, 16'h0, rdat, err);
		check("node2 pslverr", 32'(err), 32'h1);
		// Nothing may have reached a real memory
		read_word(2, 0, a0);
		read_word(2, 1, a1);
		test_done("bad node id", f);
	endtask

	// Even ops write, odd ops read words that were loaded beforehand
	task automatic node_ops(input int n);
		for (int k = 0; k < OPS; k++) begin
			if (k % 2 == 0) begin
				write_word(n, op_did[n][k], op_adr[n][k], op_dat[n][k]);
			end else begin
				read_word(n, op_did[n][k], op_adr[n][k]);
			end
		end
	endtask

	task automatic test_concurrent();
		int f;
		f = fail_cnt;
		// Bits 7:6 name the issuer, bit 5 marks a preloaded word, bits 4:2 the op
		for (int n = 0; n < NUM_NODES; n++) begin
			for (int k = 0; k < OPS; k++) begin
				op_did[n][k] = int'(rand_bits(2)) % NUM_NODES;
				op_adr[n][k] = ((n + 1) << 6) | ((k % 2) << 5) | (k << 2) | int'(rand_bits(2));
				op_dat[n][k] = 16'(rand_bits(16));
				if (k % 2 == 1) begin
					write_word(n, op_did[n][k], op_adr[n][k], op_dat[n][k]);
				end
			end
		end
		fork
			node_ops(0);
			node_ops(1);
			node_ops(2);
		join
		// Preloaded words first, so that posted writes have landed before
		// their own words are read back
		for (int p = 1; p >= 0; p--) begin
			for (int n = 0; n < NUM_NODES; n++) begin
				for (int k = p; k < OPS; k += 2) begin
					read_word(n, op_did[n][k], op_adr[n][k]);
				end
			end
		end
		test_done("concurrent traffic", f);
	endtask

	// Each issuer is free while its own server answers the other node
	task automatic test_cross();
		int f;
		int a0;
		int a1;
		f = fail_cnt;
		a0 = int'(rand_bits(6));
		a1 = int'(rand_bits(6));
		write_word(0, 1, a0, 16'(rand_bits(16)));
		write_word(1, 0, a1, 16'(rand_bits(16)));
		fork
			read_word(0, 1, a0);
			read_word(1, 0, a1);
		join
		test_done("cross reads", f);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		lfsr_state = 32'h8a34;
		pass_cnt   = 0;
		fail_cnt   = 0;
		cpu_req    = '0;
		rst        = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_remote();
		test_own();
		test_bad_node();
		test_concurrent();
		test_cross();
		$display("Checks passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- design/ring_top.sv
/* Message ring top level: NUM_NODES controllers with their local memories
   joined into one closed ring */
module ring_top #(
	parameter int NUM_NODES = 3,
	parameter int MEM_WORDS = 256
) (
	input  logic                               clk_i,
	input  logic                               rst_i,
	input  ring_pkg::apb_req_t [NUM_NODES-1:0] cpu_req_i,
	output ring_pkg::apb_rsp_t [NUM_NODES-1:0] cpu_rsp_o
);

	// ring[k] is the slot leaving node k
	ring_pkg::ring_packet_t [NUM_NODES-1:0] ring;
	ring_pkg::apb_req_t     [NUM_NODES-1:0] mem_req;
	ring_pkg::apb_rsp_t     [NUM_NODES-1:0] mem_rsp;

	for (genvar k = 0; k < NUM_NODES; k++) begin : g_node
		// Upstream neighbour, node 0 takes its slot from the last node
		localparam int PREV = (k == 0) ? NUM_NODES - 1 : k - 1;

		ring_nic #(
			.NUM_NODES(NUM_NODES),
			.NODE_ID  (k)
		) u_nic (
			.clk_i    (clk_i),
			.rst_i    (rst_i),
			.cpu_req_i(cpu_req_i[k]),
			.cpu_rsp_o(cpu_rsp_o[k]),
			.ring_i   (ring[PREV]),
			.ring_o   (ring[k]),
			.mem_req_o(mem_req[k]),
			.mem_rsp_i(mem_rsp[k])
		);

		// Each node owns one memory that only its server reaches
		ring_mem #(
			.MEM_WORDS(MEM_WORDS)
		) u_mem (
			.clk_i(clk_i),
			.rst_i(rst_i),
			.req_i(mem_req[k]),
			.rsp_o(mem_rsp[k])
		);
	end

endmodule

//--- design/ring_nic.sv
/* Ring interface controller: CPU-side request issuer, ring slot arbiter
   and the remote-request server with its APB master */
module ring_nic #(
	parameter int NUM_NODES = 3,
	parameter int NODE_ID   = 0
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  ring_pkg::apb_req_t     cpu_req_i,
	output ring_pkg::apb_rsp_t     cpu_rsp_o,
	input  ring_pkg::ring_packet_t ring_i,
	output ring_pkg::ring_packet_t ring_o,
	output ring_pkg::apb_req_t     mem_req_o,
	input  ring_pkg::apb_rsp_t     mem_rsp_i
);

	// Own id at the width of the packet id fields
	localparam logic [ring_pkg::NODE_W-1:0] MY_ID = NODE_ID[ring_pkg::NODE_W-1:0];

	// Request issuer, one CPU access in flight at most
	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_XMIT,
		REQ_WAIT
	} req_state_e;

	// Server for requests that other nodes send to the local memory
	typedef enum logic [1:0] {
		SRV_IDLE,
		SRV_SETUP,
		SRV_ACCESS,
		SRV_REPLY
	} srv_state_e;

	req_state_e req_state;
	srv_state_e srv_state;

	// The ring slot that lives in this node
	ring_pkg::ring_packet_t ring_q;
	ring_pkg::ring_packet_t ring_d;
	// Request taken off the ring, its data field later holds the read result
	ring_pkg::ring_packet_t srv_pkt;
	// Packets that this node may insert
	ring_pkg::ring_packet_t req_pkt;
	ring_pkg::ring_packet_t rep_pkt;

	// Read data from the returning ACK and the flag that completes the read
	logic [ring_pkg::DAT_W-1:0] rdata_q;
	logic                       rd_done_q;

	logic [ring_pkg::NODE_W-1:0] cpu_did;
	logic                        cpu_access;
	logic                        bad_id;
	logic                        ack_hit;
	logic                        req_hit;
	logic                        slot_free;
	logic                        ins_rep;
	logic                        ins_req;

	// ========================================================================
	// Decode of the CPU access and of the incoming slot
	// ========================================================================

	assign cpu_access = cpu_req_i.psel && cpu_req_i.penable;
	// The top bits of the CPU address name the destination node
	assign cpu_did = cpu_req_i.paddr[ring_pkg::PADDR_W-1 -: ring_pkg::NODE_W];
	assign bad_id  = int'(cpu_did) >= NUM_NODES;

	// An ACK for this node is always taken off the ring
	assign ack_hit = ring_i.valid && (ring_i.did == MY_ID) &&
		(ring_i.typ == ring_pkg::PT_ACK);
	// A request is taken only while the server is idle, else it keeps circling
	assign req_hit = ring_i.valid && (ring_i.did == MY_ID) &&
		(ring_i.typ != ring_pkg::PT_ACK) && (srv_state == SRV_IDLE);
	assign slot_free = !ring_i.valid || ack_hit || req_hit;

	// Slot arbitration, the pending reply goes ahead of a CPU request
	assign ins_rep = slot_free && (srv_state == SRV_REPLY);
	assign ins_req = slot_free && !ins_rep && (req_state == REQ_XMIT) &&
		cpu_access && !bad_id;

	// Request packet straight from the CPU bus, so a write can leave in the
	// first access cycle
	always_comb begin
		req_pkt       = '0;
		req_pkt.valid = 1'b1;
		req_pkt.typ   = cpu_req_i.pwrite ? ring_pkg::PT_WRITE : ring_pkg::PT_READ;
		req_pkt.sid   = MY_ID;
		req_pkt.did   = cpu_did;
		req_pkt.adr   = cpu_req_i.paddr[ring_pkg::ADR_W-1:0];
		req_pkt.dat   = cpu_req_i.pwdata;
	end

	// Reply goes back to the requesting node with the memory data
	always_comb begin
		rep_pkt       = '0;
		rep_pkt.valid = 1'b1;
		rep_pkt.typ   = ring_pkg::PT_ACK;
		rep_pkt.sid   = MY_ID;
		rep_pkt.did   = srv_pkt.sid;
		rep_pkt.adr   = srv_pkt.adr;
		rep_pkt.dat   = srv_pkt.dat;
	end

	// A freed slot that nobody fills travels on empty
	always_comb begin
		if (ins_rep) begin
			ring_d = rep_pkt;
		end else if (ins_req) begin
			ring_d = req_pkt;
		end else if (slot_free) begin
			ring_d = '0;
		end else begin
			ring_d = ring_i;
		end
	end

	// One hop per clock, the ring never stalls
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ring_q <= '0;
		end else begin
			ring_q <= ring_d;
		end
	end

	assign ring_o = ring_q;

	// ========================================================================
	// CPU-side request issuer
	// ========================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_state <= REQ_IDLE;
			rd_done_q <= 1'b0;
		end else begin
			rd_done_q <= 1'b0;
			case (req_state)
				REQ_IDLE: begin
					// Setup cycle, the first access cycle is spent in XMIT
					if (cpu_req_i.psel && !cpu_req_i.penable) begin
						req_state <= REQ_XMIT;
					end
				end
				REQ_XMIT: begin
					if (!cpu_req_i.psel || (cpu_access && bad_id)) begin
						req_state <= REQ_IDLE;
					end else if (ins_req) begin
						// A write is posted, a read waits for its ACK
						if (cpu_req_i.pwrite) begin
							req_state <= REQ_IDLE;
						end else begin
							req_state <= REQ_WAIT;
						end
					end
				end
				REQ_WAIT: begin
					if (ack_hit) begin
						rd_done_q <= 1'b1;
						req_state <= REQ_IDLE;
					end
				end
				default: req_state <= REQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if ((req_state == REQ_WAIT) && ack_hit) begin
			rdata_q <= ring_i.dat;
		end
	end

	// Writes and bad ids finish in the access cycle, reads one cycle after the ACK
	assign cpu_rsp_o.prdata  = rdata_q;
	assign cpu_rsp_o.pready  = (ins_req && cpu_req_i.pwrite) || rd_done_q ||
		((req_state == REQ_XMIT) && cpu_access && bad_id);
	assign cpu_rsp_o.pslverr = (req_state == REQ_XMIT) && cpu_access && bad_id;

	// ========================================================================
	// Remote-request server and memory-side APB master
	// ========================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			srv_state <= SRV_IDLE;
		end else begin
			case (srv_state)
				SRV_IDLE: begin
					if (req_hit) begin
						srv_state <= SRV_SETUP;
					end
				end
				SRV_SETUP: srv_state <= SRV_ACCESS;
				SRV_ACCESS: begin
					if (mem_rsp_i.pready) begin
						if (srv_pkt.typ == ring_pkg::PT_WRITE) begin
							srv_state <= SRV_IDLE;
						end else begin
							srv_state <= SRV_REPLY;
						end
					end
				end
				SRV_REPLY: begin
					// Hold the ACK until a free slot comes by
					if (ins_rep) begin
						srv_state <= SRV_IDLE;
					end
				end
				default: srv_state <= SRV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_hit) begin
			srv_pkt <= ring_i;
		end else if ((srv_state == SRV_ACCESS) && mem_rsp_i.pready) begin
			srv_pkt.dat <= mem_rsp_i.prdata;
		end
	end

	assign mem_req_o.psel    = (srv_state == SRV_SETUP) || (srv_state == SRV_ACCESS);
	assign mem_req_o.penable = srv_state == SRV_ACCESS;
	assign mem_req_o.pwrite  = srv_pkt.typ == ring_pkg::PT_WRITE;
	assign mem_req_o.paddr   = {MY_ID, srv_pkt.adr};
	assign mem_req_o.pwdata  = srv_pkt.dat;

	// ========================================================================
	// Assertions
	// ========================================================================

	// An access phase on the memory side always opens after a setup cycle
	a_mem_setup: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(mem_req_o.penable) |-> $past(mem_req_o.psel && !mem_req_o.penable));

	// No packet on the ring names a node that does not exist
	a_ring_ids: assert property (@(posedge clk_i) disable iff (rst_i)
		ring_o.valid |-> (int'(ring_o.did) < NUM_NODES) && (int'(ring_o.sid) < NUM_NODES));

	// The CPU must still hold the transfer when a delayed read completes
	a_cpu_ready: assert property (@(posedge clk_i) disable iff (rst_i)
		cpu_rsp_o.pready |-> cpu_req_i.psel);

endmodule

//--- design/ring_mem.sv
/* Local word memory of one node, an APB slave with zero wait states */
module ring_mem #(
	parameter int MEM_WORDS = 256
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  ring_pkg::apb_req_t req_i,
	output ring_pkg::apb_rsp_t rsp_o
);

	// Word index width, only the low address bits reach the array
	localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [ring_pkg::DAT_W-1:0] mem [MEM_WORDS];
	logic [ring_pkg::DAT_W-1:0] rdata_q;
	logic [AW-1:0]              widx;
	logic                       ready_q;

	assign widx = req_i.paddr[AW-1:0];

	// Ready follows every setup cycle, so the first access cycle completes
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= req_i.psel && !req_i.penable;
		end
	end

	// Read in the setup cycle so that prdata is valid with pready
	// Write at the end of the access cycle
	always_ff @(posedge clk_i) begin
		if (req_i.psel && !req_i.penable) begin
			rdata_q <= mem[widx];
		end
		if (req_i.psel && req_i.penable && req_i.pwrite && ready_q) begin
			mem[widx] <= req_i.pwdata;
		end
	end

	assign rsp_o.prdata  = rdata_q;
	assign rsp_o.pready  = ready_q;
	assign rsp_o.pslverr = 1'b0;

	// The address read in setup must be the one that completes the access
	a_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		req_i.psel && !req_i.penable |=> $stable(req_i.paddr));

endmodule

//--- design/ring_pkg.sv
/* Shared definitions of the message ring: field widths, the packet type,
   the ring packet and the APB request and response structs */
package ring_pkg;

	// ========================================================================
	// Field widths
	// ========================================================================

	// Node id width, enough for sixteen nodes
	localparam int NODE_W = 4;
	// Word address inside one node's local memory
	localparam int ADR_W = 12;
	// Data width of the ring and of both APB sides
	localparam int DAT_W = 16;
	// APB address, the node id sits on top of the word address
	localparam int PADDR_W = NODE_W + ADR_W;

	// ========================================================================
	// Ring packet
	// ========================================================================

	// Kind of packet held in a ring slot
	typedef enum logic [1:0] {
		PT_READ  = 2'd0,
		PT_WRITE = 2'd1,
		PT_ACK   = 2'd2
	} ring_ptype_e;

	// One ring slot, 39 bits wide
	// An ACK carries the read data back to the node named in did
	typedef struct packed {
		logic              valid;
		ring_ptype_e       typ;
		logic [NODE_W-1:0] sid;
		logic [NODE_W-1:0] did;
		logic [ADR_W-1:0]  adr;
		logic [DAT_W-1:0]  dat;
	} ring_packet_t;

	// ========================================================================
	// APB
	// ========================================================================

	// Requester side of an APB port, 35 bits
	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [PADDR_W-1:0] paddr;
		logic [DAT_W-1:0]   pwdata;
	} apb_req_t;

	// Completer side of an APB port, 18 bits
	typedef struct packed {
		logic [DAT_W-1:0] prdata;
		logic             pready;
		logic             pslverr;
	} apb_rsp_t;

endpackage
